//--- vrf_access_top.f
+incdir+.
vrf_pkg.sv
vrf_mem_if.sv
vrf_iter_ctr.sv
vrf_agu.sv
vrf_sequencer.sv
vrf_access_top.sv
tb_vrf_access.sv

//--- tb_vrf_access.sv
`include "vrf_settings.svh"

module tb_vrf_access;

  localparam int OP_TIMEOUT = 1000;

  logic                       clk_i = 1'b0;
  logic                       rst_ni;
  logic                       req_i;
  logic [2:0]                 sel_operation_i;
  vrf_pkg::vlmul_e            lmul_i;
  vrf_pkg::vsew_e             sew_i;
  logic [`VRF_REG_ADDR_W-1:0] raddr_a_i;
  logic [`VRF_REG_ADDR_W-1:0] raddr_b_i;
  logic [`VRF_REG_ADDR_W-1:0] waddr_i;
  logic [`VRF_WORD_W-1:0]     wdata_i;
  logic [`VRF_WORD_W-1:0]     rdata_a_o;
  logic [`VRF_WORD_W-1:0]     rdata_b_o;
  logic                       vector_done_o;
  logic                       data_req_o;
  logic                       data_we_o;
  logic [`VRF_MEM_ADDR_W-1:0] data_addr_o;
  logic [`VRF_WORD_W-1:0]     data_wdata_o;
  logic                       data_gnt_i = 1'b0;
  logic                       data_rvalid_i = 1'b0;
  logic [`VRF_WORD_W-1:0]     data_rdata_i = '0;

  // Memory model state
  logic [15:0] lfsr_state = 16'd96;
  logic [1:0]  gnt_wait;
  logic [1:0]  gnt_delay;

  // Reference bookkeeping
  logic                       first_req_seen;
  logic                       prev_stall;
  logic                       prev_we;
  logic [`VRF_MEM_ADDR_W-1:0] prev_addr;
  logic                       pend_a;
  logic                       pend_b;
  logic [`VRF_WORD_W-1:0]     exp_a;
  logic [`VRF_WORD_W-1:0]     exp_b;
  int                         grant_cnt;
  int                         acc_cnt [3];
  int                         nsteps;
  int                         exp_ptr;
  int                         exp_reg;
  int                         exp_addr;
  int                         exp_total;
  logic                       exp_we;

  vrf_access_top u_vrf_access_top (.*);

  always #50 clk_i = ~clk_i;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_delay(output logic [1:0] delay);
    for (int i = 0; i < 2; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      delay[i] = lfsr_state[0];
    end
  endtask

  function automatic logic [`VRF_WORD_W-1:0] model_data(input logic [`VRF_MEM_ADDR_W-1:0] a);
    model_data = `VRF_WORD_W'(a) ^ 32'hA5A5_0000;
  endfunction

  // Iterations are the elements of the whole register group
  function automatic int iter_count(input vrf_pkg::vlmul_e lmul, input vrf_pkg::vsew_e sew);
    int elems;
    int shift;
    elems = `VRF_VLEN / (8 << sew);
    shift = int'(lmul[1:0]) - (lmul[2] ? 4 : 0);
    if (shift >= 0) begin
      iter_count = elems << shift;
    end else begin
      iter_count = elems >> -shift;
    end
  endfunction

  // Selected steps run in order A, B, result
  function automatic int step_ptr(input logic [2:0] sel, input int idx);
    int n;
    step_ptr = 2;
    n = 0;
    for (int i = 0; i < 3; i++) begin
      if (sel[i]) begin
        if (n == idx) step_ptr = i;
        n++;
      end
    end
  endfunction

  task automatic report_and_stop(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "check failed");
  endtask

  //////////////////////////////////////////////////
  // Memory model and reference
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      data_gnt_i    <= 1'b0;
      data_rvalid_i <= 1'b0;
      gnt_wait      <= 2'd1;
    end else begin
      data_rvalid_i <= 1'b0;
      if (data_req_o && data_gnt_i) begin
        draw_delay(gnt_delay);
        gnt_wait   <= gnt_delay;
        data_gnt_i <= (gnt_delay == 2'd0);
        if (!data_we_o) begin
          data_rvalid_i <= 1'b1;
          data_rdata_i  <= model_data(data_addr_o);
        end
      end else if (data_req_o) begin
        gnt_wait   <= gnt_wait - 2'd1;
        data_gnt_i <= (gnt_wait == 2'd1);
      end
    end
  end

  always_comb begin
    nsteps    = $countones(sel_operation_i);
    exp_ptr   = (nsteps == 0) ? 0 : step_ptr(sel_operation_i, grant_cnt % nsteps);
    exp_reg   = (exp_ptr == 0) ? int'(raddr_a_i) :
                (exp_ptr == 1) ? int'(raddr_b_i) : int'(waddr_i);
    exp_addr  = exp_reg * `VRF_WORDS_PER_REG + acc_cnt[exp_ptr];
    exp_we    = (exp_ptr == 2);
    exp_total = iter_count(lmul_i, sew_i) * nsteps;
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_req_seen <= 1'b0;
      prev_stall     <= 1'b0;
      prev_we        <= 1'b0;
      prev_addr      <= '0;
      pend_a         <= 1'b0;
      pend_b         <= 1'b0;
      exp_a          <= '0;
      exp_b          <= '0;
      grant_cnt      <= 0;
      acc_cnt        <= '{0, 0, 0};
    end else begin
      if (req_i) first_req_seen <= 1'b1;
      prev_stall <= data_req_o && !data_gnt_i;
      prev_we    <= data_we_o;
      prev_addr  <= data_addr_o;
      pend_a     <= 1'b0;
      pend_b     <= 1'b0;
      if (vector_done_o) begin
        grant_cnt <= 0;
        acc_cnt   <= '{0, 0, 0};
      end else if (data_req_o && data_gnt_i) begin
        grant_cnt        <= grant_cnt + 1;
        acc_cnt[exp_ptr] <= acc_cnt[exp_ptr] + 1;
        if (exp_ptr == 0) begin
          exp_a  <= model_data(`VRF_MEM_ADDR_W'(exp_addr));
          pend_a <= 1'b1;
        end
        if (exp_ptr == 1) begin
          exp_b  <= model_data(`VRF_MEM_ADDR_W'(exp_addr));
          pend_b <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_quiet_after_reset: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !first_req_seen |-> !data_req_o && !data_we_o && !vector_done_o)
    else report_and_stop($sformatf(
      "error before first request: data_req_o %h data_we_o %h vector_done_o %h",
      $sampled(data_req_o), $sampled(data_we_o), $sampled(vector_done_o)));

  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    prev_stall |-> data_req_o)
    else report_and_stop("data_req_o dropped before data_gnt_i");

  a_we_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    prev_stall |-> data_we_o == prev_we)
    else report_and_stop($sformatf("error data_we_o: got %h expected %h",
      $sampled(data_we_o), $sampled(prev_we)));

  a_addr_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    prev_stall |-> data_addr_o == prev_addr)
    else report_and_stop($sformatf("error data_addr_o: got %h expected %h",
      $sampled(data_addr_o), $sampled(prev_addr)));

  a_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o && data_gnt_i |-> data_addr_o == `VRF_MEM_ADDR_W'(exp_addr))
    else report_and_stop($sformatf("error data_addr_o: got %h expected %h",
      $sampled(data_addr_o), $sampled(exp_addr)));

  a_we: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o && data_gnt_i |-> data_we_o == exp_we)
    else report_and_stop($sformatf("error data_we_o: got %h expected %h",
      $sampled(data_we_o), $sampled(exp_we)));

  a_wdata: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o && data_gnt_i && data_we_o |-> data_wdata_o == wdata_i)
    else report_and_stop($sformatf("error data_wdata_o: got %h expected %h",
      $sampled(data_wdata_o), $sampled(wdata_i)));

  a_rdata_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_rvalid_i && pend_a |=> rdata_a_o == exp_a)
    else report_and_stop($sformatf("error rdata_a_o: got %h expected %h",
      $sampled(rdata_a_o), $sampled(exp_a)));

  a_rdata_b: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_rvalid_i && pend_b |=> rdata_b_o == exp_b)
    else report_and_stop($sformatf("error rdata_b_o: got %h expected %h",
      $sampled(rdata_b_o), $sampled(exp_b)));

  a_done_in_op: assert property (@(posedge clk_i) disable iff (!rst_ni)
    vector_done_o |-> req_i)
    else report_and_stop("vector_done_o pulsed with no operation in progress");

  a_done_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
    vector_done_o |-> grant_cnt == exp_total)
    else report_and_stop($sformatf(
      "error granted accesses at vector_done_o: got %h expected %h",
      $sampled(grant_cnt), $sampled(exp_total)));

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic run_op(input logic [2:0] sel, input vrf_pkg::vlmul_e lmul,
                        input vrf_pkg::vsew_e sew, input logic [4:0] ra,
                        input logic [4:0] rb, input logic [4:0] rd,
                        input logic [`VRF_WORD_W-1:0] wdata);
    int waited;
    waited = 0;
    req_i           <= 1'b1;
    sel_operation_i <= sel;
    lmul_i          <= lmul;
    sew_i           <= sew;
    raddr_a_i       <= ra;
    raddr_b_i       <= rb;
    waddr_i         <= rd;
    wdata_i         <= wdata;
    @(posedge clk_i);
    while (!vector_done_o && waited < OP_TIMEOUT) begin
      @(posedge clk_i);
      waited++;
    end
    if (!vector_done_o) begin
      report_and_stop("operation timed out waiting for vector_done_o");
    end else begin
      req_i <= 1'b0;
      @(posedge clk_i);
    end
  endtask

  initial begin
    rst_ni          <= 1'b0;
    req_i           <= 1'b0;
    sel_operation_i <= 3'b000;
    lmul_i          <= vrf_pkg::LMUL_1;
    sew_i           <= vrf_pkg::SEW_32;
    raddr_a_i       <= '0;
    raddr_b_i       <= '0;
    waddr_i         <= '0;
    wdata_i         <= '0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    // A few idle cycles before the first operation
    repeat (3) @(posedge clk_i);
    run_op(3'b111, vrf_pkg::LMUL_1, vrf_pkg::SEW_32, 5'd1, 5'd2, 5'd3, 32'h1234_5678);
    run_op(3'b011, vrf_pkg::LMUL_2, vrf_pkg::SEW_16, 5'd4, 5'd8, 5'd12, 32'h0BAD_F00D);
    run_op(3'b100, vrf_pkg::LMUL_1_2, vrf_pkg::SEW_8, 5'd0, 5'd0, 5'd20, 32'hCAFE_0001);
    run_op(3'b111, vrf_pkg::LMUL_1_4, vrf_pkg::SEW_32, 5'd5, 5'd6, 5'd7, 32'h5555_AAAA);
    run_op(3'b011, vrf_pkg::LMUL_4, vrf_pkg::SEW_32, 5'd10, 5'd14, 5'd18, 32'h0000_FFFF);
    run_op(3'b100, vrf_pkg::LMUL_1, vrf_pkg::SEW_16, 5'd9, 5'd11, 5'd24, 32'h8765_4321);
    run_op(3'b111, vrf_pkg::LMUL_1_8, vrf_pkg::SEW_8, 5'd25, 5'd26, 5'd27, 32'hDEAD_BEEF);
    run_op(3'b011, vrf_pkg::LMUL_1_2, vrf_pkg::SEW_16, 5'd30, 5'd31, 5'd2, 32'h1357_9BDF);
    run_op(3'b111, vrf_pkg::LMUL_2, vrf_pkg::SEW_32, 5'd16, 5'd20, 5'd24, 32'h2468_ACE0);
    repeat (2) @(posedge clk_i);
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- vrf_access_top.sv
`include "vrf_settings.svh"

module vrf_access_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Pipeline side
  input  logic                       req_i,
  input  logic [2:0]                 sel_operation_i,
  input  vrf_pkg::vlmul_e            lmul_i,
  input  vrf_pkg::vsew_e             sew_i,
  input  logic [`VRF_REG_ADDR_W-1:0] raddr_a_i,
  input  logic [`VRF_REG_ADDR_W-1:0] raddr_b_i,
  input  logic [`VRF_REG_ADDR_W-1:0] waddr_i,
  input  logic [`VRF_WORD_W-1:0]     wdata_i,
  output logic [`VRF_WORD_W-1:0]     rdata_a_o,
  output logic [`VRF_WORD_W-1:0]     rdata_b_o,
  output logic                       vector_done_o,
  // VRF memory bus
  output logic                       data_req_o,
  output logic                       data_we_o,
  output logic [`VRF_MEM_ADDR_W-1:0] data_addr_o,
  output logic [`VRF_WORD_W-1:0]     data_wdata_o,
  input  logic                       data_gnt_i,
  input  logic                       data_rvalid_i,
  input  logic [`VRF_WORD_W-1:0]     data_rdata_i
);

  vrf_mem_if mem_bus ();

  logic              agu_load;
  vrf_pkg::vrf_ptr_e agu_sel;
  logic              agu_incr;
  logic              cnt_load;
  logic              cnt_dec;
  logic              cnt_last;

  //////////////////////////////////////////////////
  // Memory bus to top-level ports
  //////////////////////////////////////////////////

  assign data_req_o     = mem_bus.req;
  assign data_we_o      = mem_bus.we;
  assign data_addr_o    = mem_bus.addr;
  assign mem_bus.wdata  = wdata_i;
  assign data_wdata_o   = mem_bus.wdata;
  assign mem_bus.gnt    = data_gnt_i;
  assign mem_bus.rvalid = data_rvalid_i;
  assign mem_bus.rdata  = data_rdata_i;

  vrf_sequencer u_vrf_sequencer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .sel_operation_i (sel_operation_i),
    .mem             (mem_bus.seq),
    .agu_load_o      (agu_load),
    .agu_sel_o       (agu_sel),
    .agu_incr_o      (agu_incr),
    .cnt_load_o      (cnt_load),
    .cnt_dec_o       (cnt_dec),
    .cnt_last_i      (cnt_last),
    .vector_done_o   (vector_done_o),
    .rdata_a_o       (rdata_a_o),
    .rdata_b_o       (rdata_b_o)
  );

  vrf_agu u_vrf_agu (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (raddr_a_i),
    .raddr_b_i (raddr_b_i),
    .waddr_i   (waddr_i),
    .load_i    (agu_load),
    .sel_i     (agu_sel),
    .incr_i    (agu_incr),
    .mem       (mem_bus.agu)
  );

  vrf_iter_ctr u_vrf_iter_ctr (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .load_i (cnt_load),
    .lmul_i (lmul_i),
    .sew_i  (sew_i),
    .dec_i  (cnt_dec),
    .last_o (cnt_last)
  );

endmodule

//--- vrf_sequencer.sv
`include "vrf_settings.svh"

module vrf_sequencer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  // Bit 0 reads operand A, bit 1 reads operand B, bit 2 writes the result
  input  logic [2:0]             sel_operation_i,
  vrf_mem_if.seq                 mem,
  output logic                   agu_load_o,
  output vrf_pkg::vrf_ptr_e      agu_sel_o,
  output logic                   agu_incr_o,
  output logic                   cnt_load_o,
  output logic                   cnt_dec_o,
  input  logic                   cnt_last_i,
  output logic                   vector_done_o,
  output logic [`VRF_WORD_W-1:0] rdata_a_o,
  output logic [`VRF_WORD_W-1:0] rdata_b_o
);

  vrf_pkg::vrf_state_e state_q;
  vrf_pkg::vrf_state_e state_d;

  // First selected access of an iteration
  vrf_pkg::vrf_ptr_e   first_ptr;
  vrf_pkg::vrf_state_e first_state;
  logic                first_we;

  logic issue_first;
  logic next_iter;
  logic cap_a;
  logic cap_b;

  always_comb begin
    if (sel_operation_i[0]) begin
      first_ptr   = vrf_pkg::PTR_RS1;
      first_we    = 1'b0;
      first_state = vrf_pkg::VRF_READ1;
    end else if (sel_operation_i[1]) begin
      first_ptr   = vrf_pkg::PTR_RS2;
      first_we    = 1'b0;
      first_state = vrf_pkg::VRF_READ2;
    end else begin
      first_ptr   = vrf_pkg::PTR_RD;
      first_we    = 1'b1;
      first_state = vrf_pkg::VRF_WRITE;
    end
  end

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    mem.req       = 1'b0;
    mem.we        = 1'b0;
    agu_load_o    = 1'b0;
    agu_sel_o     = vrf_pkg::PTR_RS1;
    cnt_load_o    = 1'b0;
    vector_done_o = 1'b0;
    issue_first   = 1'b0;
    next_iter     = 1'b0;
    cap_a         = 1'b0;
    cap_b         = 1'b0;

    case (state_q)
      vrf_pkg::VRF_IDLE: begin
        if (req_i) begin
          agu_load_o = 1'b1;
          cnt_load_o = 1'b1;
          state_d    = vrf_pkg::VRF_START;
        end
      end

      vrf_pkg::VRF_START: begin
        if (sel_operation_i == 3'b000) begin
          state_d = vrf_pkg::VRF_IDLE;
        end else begin
          issue_first = 1'b1;
        end
      end

      vrf_pkg::VRF_READ1: begin
        cap_a = mem.rvalid;
        // Operand A is always followed by operand B
        if (!sel_operation_i[1]) begin
          state_d = vrf_pkg::VRF_IDLE;
        end else begin
          mem.req   = 1'b1;
          agu_sel_o = vrf_pkg::PTR_RS2;
          if (mem.gnt) state_d = vrf_pkg::VRF_READ2;
        end
      end

      vrf_pkg::VRF_READ2: begin
        cap_b = mem.rvalid;
        if (sel_operation_i[2]) begin
          mem.req   = 1'b1;
          mem.we    = 1'b1;
          agu_sel_o = vrf_pkg::PTR_RD;
          if (mem.gnt) state_d = vrf_pkg::VRF_WRITE;
        end else if (cnt_last_i) begin
          vector_done_o = 1'b1;
          state_d       = vrf_pkg::VRF_IDLE;
        end else begin
          issue_first = 1'b1;
          next_iter   = 1'b1;
        end
      end

      vrf_pkg::VRF_WRITE: begin
        if (cnt_last_i) begin
          vector_done_o = 1'b1;
          state_d       = vrf_pkg::VRF_IDLE;
        end else begin
          issue_first = 1'b1;
          next_iter   = 1'b1;
        end
      end

      default: begin
        state_d = vrf_pkg::VRF_IDLE;
      end
    endcase

    if (issue_first) begin
      mem.req   = 1'b1;
      mem.we    = first_we;
      agu_sel_o = first_ptr;
      if (mem.gnt) state_d = first_state;
    end
  end

  // Pointer steps with every request, the AGU qualifies it with the grant
  assign agu_incr_o = mem.req;
  // Count only moves once the next iteration is accepted
  assign cnt_dec_o  = next_iter && mem.gnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= vrf_pkg::VRF_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////
  // Operand capture
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_a_o <= '0;
      rdata_b_o <= '0;
    end else begin
      if (cap_a) rdata_a_o <= mem.rdata;
      if (cap_b) rdata_b_o <= mem.rdata;
    end
  end

  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem.req && !mem.gnt |=> mem.req)
    else $error("request dropped before grant");

  // Read data only arrives while an operand is being captured
  a_rvalid_in_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem.rvalid |-> state_q inside {vrf_pkg::VRF_READ1, vrf_pkg::VRF_READ2})
    else $error("read data returned outside a read state");

endmodule

//--- vrf_agu.sv
`include "vrf_settings.svh"

module vrf_agu (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [`VRF_REG_ADDR_W-1:0] raddr_a_i,
  input  logic [`VRF_REG_ADDR_W-1:0] raddr_b_i,
  input  logic [`VRF_REG_ADDR_W-1:0] waddr_i,
  input  logic                       load_i,
  input  vrf_pkg::vrf_ptr_e          sel_i,
  input  logic                       incr_i,
  vrf_mem_if.agu                     mem
);

  logic [`VRF_MEM_ADDR_W-1:0] rs1_ptr_q;
  logic [`VRF_MEM_ADDR_W-1:0] rs2_ptr_q;
  logic [`VRF_MEM_ADDR_W-1:0] rd_ptr_q;
  logic                       advance;

  // First word of a vector register
  function automatic logic [`VRF_MEM_ADDR_W-1:0] reg_base(
    input logic [`VRF_REG_ADDR_W-1:0] reg_num
  );
    reg_base = `VRF_MEM_ADDR_W'(reg_num * `VRF_WORDS_PER_REG);
  endfunction

  assign advance = incr_i && mem.gnt;

  //////////////////////////////////////////////////
  // Word pointers
  //////////////////////////////////////////////////

  // Grouped registers are walked linearly into the next ones
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rs1_ptr_q <= '0;
      rs2_ptr_q <= '0;
      rd_ptr_q  <= '0;
    end else if (load_i) begin
      rs1_ptr_q <= reg_base(raddr_a_i);
      rs2_ptr_q <= reg_base(raddr_b_i);
      rd_ptr_q  <= reg_base(waddr_i);
    end else if (advance) begin
      case (sel_i)
        vrf_pkg::PTR_RS1: rs1_ptr_q <= rs1_ptr_q + 1'b1;
        vrf_pkg::PTR_RS2: rs2_ptr_q <= rs2_ptr_q + 1'b1;
        vrf_pkg::PTR_RD:  rd_ptr_q  <= rd_ptr_q + 1'b1;
        default: begin
        end
      endcase
    end
  end

  always_comb begin
    case (sel_i)
      vrf_pkg::PTR_RS2: mem.addr = rs2_ptr_q;
      vrf_pkg::PTR_RD:  mem.addr = rd_ptr_q;
      default:          mem.addr = rs1_ptr_q;
    endcase
  end

  // Address must not move under a pending request
  a_sel_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    incr_i && !mem.gnt |=> $stable(sel_i))
    else $error("pointer select changed while waiting for grant");

endmodule

//--- vrf_iter_ctr.sv
`include "vrf_settings.svh"

module vrf_iter_ctr (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            load_i,
  input  vrf_pkg::vlmul_e lmul_i,
  input  vrf_pkg::vsew_e  sew_i,
  input  logic            dec_i,
  output logic            last_o
);

  // Widest case is 8-bit elements with LMUL 8
  localparam int unsigned CNT_W = $clog2(`VRF_WORDS_PER_REG * 4 * 8 + 1);
  localparam logic [CNT_W-1:0] BASE_CNT = CNT_W'(`VRF_WORDS_PER_REG * 4);

  logic [CNT_W-1:0] elem_cnt;
  logic [CNT_W-1:0] load_cnt;
  logic [2:0]       lmul_mag;
  logic [CNT_W-1:0] cnt_q;

  //////////////////////////////////////////////////
  // Iteration count from LMUL and SEW
  //////////////////////////////////////////////////

  always_comb begin
    elem_cnt = BASE_CNT >> sew_i;
    lmul_mag = 3'd0 - lmul_i;
    if (lmul_i[2]) begin
      // Fractional grouping
      load_cnt = elem_cnt >> lmul_mag;
    end else begin
      load_cnt = elem_cnt << lmul_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= load_cnt;
    end else if (dec_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign last_o = (cnt_q == CNT_W'(1));

  // LMUL and SEW pair must leave at least one iteration
  a_cnt_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_i |=> cnt_q != '0)
    else $error("iteration count is zero after load");

endmodule

//--- vrf_mem_if.sv
`include "vrf_settings.svh"

interface vrf_mem_if ();

  logic                       req;
  logic                       we;
  logic [`VRF_MEM_ADDR_W-1:0] addr;
  logic [`VRF_WORD_W-1:0]     wdata;
  logic                       gnt;
  logic                       rvalid;
  logic [`VRF_WORD_W-1:0]     rdata;

  // Sequencer side, owns the request
  modport seq (
    output req,
    output we,
    input  gnt,
    input  rvalid,
    input  rdata
  );

  // Address generator side
  modport agu (
    output addr,
    input  gnt
  );

  // Memory side as seen from the top level
  modport port (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output gnt,
    output rvalid,
    output rdata
  );

endinterface

//--- vrf_pkg.sv
package vrf_pkg;

  // Register grouping, signed log2 of LMUL
  typedef enum logic signed [2:0] {
    LMUL_1_8 = 3'b101,
    LMUL_1_4 = 3'b110,
    LMUL_1_2 = 3'b111,
    LMUL_1   = 3'b000,
    LMUL_2   = 3'b001,
    LMUL_4   = 3'b010,
    LMUL_8   = 3'b011
  } vlmul_e;

  // Element width
  typedef enum logic [1:0] {
    SEW_8  = 2'b00,
    SEW_16 = 2'b01,
    SEW_32 = 2'b10
  } vsew_e;

  typedef enum logic [2:0] {
    VRF_IDLE,
    VRF_START,
    VRF_READ1,
    VRF_READ2,
    VRF_WRITE
  } vrf_state_e;

  // Pointer presented on the memory address
  typedef enum logic [1:0] {
    PTR_RS1,
    PTR_RS2,
    PTR_RD
  } vrf_ptr_e;

endpackage

//--- vrf_settings.svh
`ifndef VRF_SETTINGS_SVH
`define VRF_SETTINGS_SVH

//////////////////////////////////////////////////
// Vector register file sizes
//////////////////////////////////////////////////

// Vector register length in bits
`define VRF_VLEN 128

// Memory word and pipeline data port width
`define VRF_WORD_W 32

// Vector register number width
`define VRF_REG_ADDR_W 5

// Words needed to hold one vector register
`define VRF_WORDS_PER_REG (`VRF_VLEN / `VRF_WORD_W)

// Word address into the VRF memory, 32 registers of 4 words
`define VRF_MEM_ADDR_W 7

`endif
